// File: include/pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Machine word
`define DATA_WIDTH 32

// Register file geometry
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// Instruction fields
`define SHAMT_WIDTH 5
`define IMM_WIDTH 16

`endif

// File: source/isaPkg.sv
`default_nettype none

`include "pipe_config.svh"

package isaPkg;

    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

    // Kept MIPS32 major opcodes
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opAddi    = 6'h08,
        opSlti    = 6'h0A,
        opAndi    = 6'h0C,
        opOri     = 6'h0D,
        opXori    = 6'h0E,
        opLui     = 6'h0F
    } opcode_e;

    // SPECIAL funct codes
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnSlt = 6'h2A
    } funct_e;

    // R-type layout, immediate overlays rd, shamt and funct
    typedef struct packed {
        logic [5:0]              opcode;
        regAddr_t                rs;
        regAddr_t                rt;
        regAddr_t                rd;
        logic [`SHAMT_WIDTH-1:0] shamt;
        logic [5:0]              funct;
    } instruction_t;

endpackage

`default_nettype wire

// File: source/pipePkg.sv
`default_nettype none

`include "pipe_config.svh"

package pipePkg;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5,
        aluSll = 4'd6,
        aluSrl = 4'd7,
        aluLui = 4'd8
    } aluOp_e;

    // Decode to execute payload
    typedef struct packed {
        logic                    valid;
        logic                    regWrite;
        logic                    useImm;
        aluOp_e                  aluOp;
        isaPkg::regAddr_t        rs;
        isaPkg::regAddr_t        rt;
        isaPkg::regAddr_t        rd;
        logic [`SHAMT_WIDTH-1:0] shamt;
        isaPkg::word_t           rsData;
        isaPkg::word_t           rtData;
        isaPkg::word_t           imm;
    } decoded_t;

    // Output stream and register write port
    typedef struct packed {
        isaPkg::regAddr_t dest;
        isaPkg::word_t    data;
    } result_t;

endpackage

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_config.svh"

module regFile (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             writeEn_i,
    input  pipePkg::result_t      write_i,
    input  isaPkg::regAddr_t      rsAddr_i,
    input  isaPkg::regAddr_t      rtAddr_i,
    output isaPkg::word_t         rsData_o,
    output isaPkg::word_t         rtData_o
);

    isaPkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn_i && write_i.dest != '0) begin
            regs[write_i.dest] <= write_i.data;
        end
    end

    // Write-through so decode sees a value retiring this cycle
    always_comb begin
        if (rsAddr_i == '0) begin
            rsData_o = '0;
        end else if (writeEn_i && write_i.dest == rsAddr_i) begin
            rsData_o = write_i.data;
        end else begin
            rsData_o = regs[rsAddr_i];
        end
    end

    always_comb begin
        if (rtAddr_i == '0) begin
            rtData_o = '0;
        end else if (writeEn_i && write_i.dest == rtAddr_i) begin
            rtData_o = write_i.data;
        end else begin
            rtData_o = regs[rtAddr_i];
        end
    end

    zeroRegHeld: assert property (@(posedge clk) disable iff (rst)
        (writeEn_i && write_i.dest == '0) |=> regs[0] == '0);

endmodule

`default_nettype wire

// File: source/instDecode.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_config.svh"

module instDecode (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             advance_i,
    input  wire logic             instValid_i,
    input  isaPkg::instruction_t  inst_i,
    input  wire logic             writeEn_i,
    input  pipePkg::result_t      write_i,
    output pipePkg::decoded_t     decoded_o
);

    isaPkg::instruction_t instReg;
    logic                 instValid;
    pipePkg::aluOp_e      aluOp;
    logic                 known;
    logic                 useImm;
    logic                 signExt;
    logic [`IMM_WIDTH-1:0] imm;
    isaPkg::word_t        rsData;
    isaPkg::word_t        rtData;

    always_ff @(posedge clk) begin
        if (rst) begin
            instValid <= 1'b0;
        end else if (advance_i) begin
            instValid <= instValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i && instValid_i) begin
            instReg <= inst_i;
        end
    end

    // Control decode
    always_comb begin
        aluOp   = pipePkg::aluAdd;
        known   = 1'b1;
        useImm  = 1'b1;
        signExt = 1'b0;
        case (instReg.opcode)
            isaPkg::opSpecial: begin
                useImm = 1'b0;
                case (instReg.funct)
                    isaPkg::fnSll: aluOp = pipePkg::aluSll;
                    isaPkg::fnSrl: aluOp = pipePkg::aluSrl;
                    isaPkg::fnAdd: aluOp = pipePkg::aluAdd;
                    isaPkg::fnSub: aluOp = pipePkg::aluSub;
                    isaPkg::fnAnd: aluOp = pipePkg::aluAnd;
                    isaPkg::fnOr:  aluOp = pipePkg::aluOr;
                    isaPkg::fnXor: aluOp = pipePkg::aluXor;
                    isaPkg::fnSlt: aluOp = pipePkg::aluSlt;
                    default:       known = 1'b0;
                endcase
            end
            isaPkg::opAddi: begin
                aluOp   = pipePkg::aluAdd;
                signExt = 1'b1;
            end
            isaPkg::opSlti: begin
                aluOp   = pipePkg::aluSlt;
                signExt = 1'b1;
            end
            isaPkg::opAndi: aluOp = pipePkg::aluAnd;
            isaPkg::opOri:  aluOp = pipePkg::aluOr;
            isaPkg::opXori: aluOp = pipePkg::aluXor;
            isaPkg::opLui:  aluOp = pipePkg::aluLui;
            default:        known = 1'b0;
        endcase
    end

    assign imm = instReg[`IMM_WIDTH-1:0];

    regFile regFileInst (
        .clk       (clk),
        .rst       (rst),
        .writeEn_i (writeEn_i),
        .write_i   (write_i),
        .rsAddr_i  (instReg.rs),
        .rtAddr_i  (instReg.rt),
        .rsData_o  (rsData),
        .rtData_o  (rtData)
    );

    always_comb begin
        decoded_o.valid    = instValid && known;
        decoded_o.regWrite = known;
        decoded_o.useImm   = useImm;
        decoded_o.aluOp    = aluOp;
        decoded_o.rs       = instReg.rs;
        decoded_o.rt       = instReg.rt;
        // Immediates target rt
        decoded_o.rd       = useImm ? instReg.rt : instReg.rd;
        decoded_o.shamt    = instReg.shamt;
        decoded_o.rsData   = rsData;
        decoded_o.rtData   = rtData;
        decoded_o.imm      = {{(`DATA_WIDTH-`IMM_WIDTH){signExt & imm[`IMM_WIDTH-1]}}, imm};
    end

endmodule

`default_nettype wire

// File: source/aluExecute.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_config.svh"

module aluExecute (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          advance_i,
    input  pipePkg::decoded_t  decoded_i,
    input  pipePkg::result_t   fwd_i,
    input  wire logic          fwdValid_i,
    output pipePkg::result_t   exec_o,
    output logic               execValid_o
);

    pipePkg::decoded_t exReg;
    logic              fwdRs;
    logic              fwdRt;
    isaPkg::word_t     opA;
    isaPkg::word_t     rtVal;
    isaPkg::word_t     opB;
    isaPkg::word_t     aluRes;

    // Only the valid flag needs clearing
    always_ff @(posedge clk) begin
        if (rst) begin
            exReg.valid <= 1'b0;
        end else if (advance_i) begin
            exReg <= decoded_i;
        end
    end

    // Forward from the result register, never for r0
    assign fwdRs = fwdValid_i && fwd_i.dest != '0 && fwd_i.dest == exReg.rs;
    assign fwdRt = fwdValid_i && fwd_i.dest != '0 && fwd_i.dest == exReg.rt;

    assign opA   = fwdRs ? fwd_i.data : exReg.rsData;
    assign rtVal = fwdRt ? fwd_i.data : exReg.rtData;
    assign opB   = exReg.useImm ? exReg.imm : rtVal;

    always_comb begin
        case (exReg.aluOp)
            pipePkg::aluAdd: aluRes = opA + opB;
            pipePkg::aluSub: aluRes = opA - opB;
            pipePkg::aluAnd: aluRes = opA & opB;
            pipePkg::aluOr:  aluRes = opA | opB;
            pipePkg::aluXor: aluRes = opA ^ opB;
            pipePkg::aluSlt: aluRes = isaPkg::word_t'($signed(opA) < $signed(opB));
            // Shifts act on rt
            pipePkg::aluSll: aluRes = rtVal << exReg.shamt;
            pipePkg::aluSrl: aluRes = rtVal >> exReg.shamt;
            pipePkg::aluLui: aluRes = exReg.imm << `IMM_WIDTH;
            default:         aluRes = '0;
        endcase
    end

    assign exec_o.dest = exReg.rd;
    assign exec_o.data = aluRes;
    assign execValid_o = exReg.valid && exReg.regWrite;

    aluOpDefined: assert property (@(posedge clk) disable iff (rst)
        execValid_o |-> exReg.aluOp inside {
            pipePkg::aluAdd, pipePkg::aluSub, pipePkg::aluAnd,
            pipePkg::aluOr, pipePkg::aluXor, pipePkg::aluSlt,
            pipePkg::aluSll, pipePkg::aluSrl, pipePkg::aluLui
        });

endmodule

`default_nettype wire

// File: source/resultStage.sv
`timescale 1ns/1ns
`default_nettype none

module resultStage (
    input  wire logic         clk,
    input  wire logic         rst,
    input  pipePkg::result_t  exec_i,
    input  wire logic         execValid_i,
    input  wire logic         resultReady_i,
    output logic              resultValid_o,
    output pipePkg::result_t  result_o,
    output logic              advance_o,
    output logic              writeEn_o,
    output pipePkg::result_t  write_o
);

    logic             resValid;
    pipePkg::result_t resReg;

    // Global stall only when a held result is refused
    assign advance_o = !(resValid && !resultReady_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else if (advance_o) begin
            resValid <= execValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            resReg <= exec_i;
        end
    end

    assign resultValid_o = resValid;
    assign result_o      = resReg;

    // Writes back on the transfer edge
    assign writeEn_o = resValid && resultReady_i && resReg.dest != '0;
    assign write_o   = resReg;

    holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
        (resultValid_o && !resultReady_i) |=> resultValid_o && $stable(result_o));

endmodule

`default_nettype wire

// File: source/pipeTop.sv
`timescale 1ns/1ns
`default_nettype none

module pipeTop (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             instValid_i,
    output logic                  instReady_o,
    input  isaPkg::instruction_t  inst_i,
    output logic                  resultValid_o,
    input  wire logic             resultReady_i,
    output pipePkg::result_t      result_o
);

    logic              advance;
    pipePkg::decoded_t decoded;
    pipePkg::result_t  exec;
    logic              execValid;
    logic              writeEn;
    pipePkg::result_t  write;

    assign instReady_o = advance;

    instDecode decodeInst (
        .clk         (clk),
        .rst         (rst),
        .advance_i   (advance),
        .instValid_i (instValid_i),
        .inst_i      (inst_i),
        .writeEn_i   (writeEn),
        .write_i     (write),
        .decoded_o   (decoded)
    );

    // Result register doubles as the forwarding source
    aluExecute executeInst (
        .clk         (clk),
        .rst         (rst),
        .advance_i   (advance),
        .decoded_i   (decoded),
        .fwd_i       (result_o),
        .fwdValid_i  (resultValid_o),
        .exec_o      (exec),
        .execValid_o (execValid)
    );

    resultStage resultInst (
        .clk           (clk),
        .rst           (rst),
        .exec_i        (exec),
        .execValid_i   (execValid),
        .resultReady_i (resultReady_i),
        .resultValid_o (resultValid_o),
        .result_o      (result_o),
        .advance_o     (advance),
        .writeEn_o     (writeEn),
        .write_o       (write)
    );

endmodule

`default_nettype wire

// File: testbench/pipeTb.sv
`timescale 1ns/1ns
`default_nettype none

module pipeTb;

    localparam int numInsts   = 400;
    localparam int fixedReady = 40;
    // Four cycles per instruction under back-pressure, plus drain margin
    localparam int cycleLimit = numInsts * 4 + numInsts;

    typedef struct packed {
        pipePkg::result_t expected;
        int               acceptCycle;
        int               stallMark;
    } pending_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 instValid;
    logic                 instReady;
    isaPkg::instruction_t inst;
    logic                 resultValid;
    logic                 resultReady;
    pipePkg::result_t     result;

    isaPkg::word_t    modelRegs [32];
    pending_t         pendingQ [$];
    pending_t         head;
    pipePkg::result_t heldResult;
    logic             heldLast = 1'b0;
    logic [31:0]      rngState = 32'd16;
    logic [31:0]      draw;
    int               cycle = 0;
    int               stallCount = 0;
    int               acceptedCount = 0;
    int               checkedCount = 0;
    int               issued = 0;

    pipeTop UUT (
        .clk           (clk),
        .rst           (rst),
        .instValid_i   (instValid),
        .instReady_o   (instReady),
        .inst_i        (inst),
        .resultValid_o (resultValid),
        .resultReady_i (resultReady),
        .result_o      (result)
    );

    always #4 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
        if (got !== expected) begin
            abortRun($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
        end
    endtask

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] drawRandom();
        rngState = lcgNext(rngState);
        return rngState;
    endfunction

    // Legal instruction on r0..r7, upper LCG bits only
    function automatic isaPkg::instruction_t makeInst();
        logic [31:0]          pick;
        logic [31:0]          fields;
        logic [31:0]          immBits;
        int                   kind;
        isaPkg::instruction_t i;
        pick    = drawRandom();
        fields  = drawRandom();
        immBits = drawRandom();
        kind    = int'(pick[31:16] % 16'd14);
        i       = '0;
        i.rs    = {2'b00, fields[31:29]};
        i.rt    = {2'b00, fields[28:26]};
        if (kind < 8) begin
            i.opcode = isaPkg::opSpecial;
            i.rd     = {2'b00, fields[25:23]};
            case (kind)
                0: i.funct = isaPkg::fnAdd;
                1: i.funct = isaPkg::fnSub;
                2: i.funct = isaPkg::fnAnd;
                3: i.funct = isaPkg::fnOr;
                4: i.funct = isaPkg::fnXor;
                5: i.funct = isaPkg::fnSlt;
                6: i.funct = isaPkg::fnSll;
                default: i.funct = isaPkg::fnSrl;
            endcase
            if (kind >= 6) begin
                i.shamt = fields[22:18];
            end
        end else begin
            case (kind)
                8: i.opcode = isaPkg::opAddi;
                9: i.opcode = isaPkg::opSlti;
                10: i.opcode = isaPkg::opAndi;
                11: i.opcode = isaPkg::opOri;
                12: i.opcode = isaPkg::opXori;
                default: i.opcode = isaPkg::opLui;
            endcase
            i[15:0] = immBits[31:16];
        end
        return i;
    endfunction

    function automatic pipePkg::result_t refResult(input isaPkg::instruction_t i,
                                                   input isaPkg::word_t regs [32]);
        isaPkg::word_t    a;
        isaPkg::word_t    b;
        isaPkg::word_t    sext;
        isaPkg::word_t    zext;
        logic [15:0]      imm;
        pipePkg::result_t r;
        a      = (i.rs == '0) ? '0 : regs[i.rs];
        b      = (i.rt == '0) ? '0 : regs[i.rt];
        imm    = i[15:0];
        sext   = {{16{imm[15]}}, imm};
        zext   = {16'h0000, imm};
        r.dest = i.rt;
        r.data = '0;
        case (i.opcode)
            isaPkg::opSpecial: begin
                r.dest = i.rd;
                case (i.funct)
                    isaPkg::fnAdd: r.data = a + b;
                    isaPkg::fnSub: r.data = a - b;
                    isaPkg::fnAnd: r.data = a & b;
                    isaPkg::fnOr:  r.data = a | b;
                    isaPkg::fnXor: r.data = a ^ b;
                    isaPkg::fnSlt: r.data = {31'b0, $signed(a) < $signed(b)};
                    isaPkg::fnSll: r.data = b << i.shamt;
                    default:       r.data = b >> i.shamt;
                endcase
            end
            isaPkg::opAddi: r.data = a + sext;
            isaPkg::opSlti: r.data = {31'b0, $signed(a) < $signed(sext)};
            isaPkg::opAndi: r.data = a & zext;
            isaPkg::opOri:  r.data = a | zext;
            isaPkg::opXori: r.data = a ^ zext;
            default:        r.data = {imm, 16'h0000};
        endcase
        return r;
    endfunction

    // Comparison process
    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            if (cycle > cycleLimit) begin
                abortRun($sformatf("Timeout: run still busy after %0d cycles", cycleLimit));
            end else begin
                if (instValid && instReady) begin
                    head.expected    = refResult(inst, modelRegs);
                    head.acceptCycle = cycle;
                    head.stallMark   = stallCount;
                    pendingQ.push_back(head);
                    if (head.expected.dest != '0) begin
                        modelRegs[head.expected.dest] = head.expected.data;
                    end
                    acceptedCount++;
                end
                if (resultValid && resultReady) begin
                    if (pendingQ.size() == 0) begin
                        abortRun("A result was transferred with no instruction outstanding");
                    end else begin
                        head = pendingQ.pop_front();
                        checkValue("result_o.dest", 64'(result.dest),
                                   64'(head.expected.dest));
                        checkValue("result_o.data", 64'(result.data),
                                   64'(head.expected.data));
                        // Three edges to leave, one more per stalled edge
                        checkValue("result latency", 64'(cycle - head.acceptCycle),
                                   64'(3 + stallCount - head.stallMark));
                        checkedCount++;
                    end
                end
                if (heldLast) begin
                    checkValue("resultValid_o", 64'(resultValid), 64'(1'b1));
                    checkValue("result_o", 64'(result), 64'(heldResult));
                end
                heldLast   = resultValid && !resultReady;
                heldResult = result;
                if (heldLast) begin
                    stallCount++;
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        instValid   = 1'b0;
        inst        = '0;
        resultReady = 1'b0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkValue("resultValid_o", 64'(resultValid), 64'(1'b0));
        checkValue("instReady_o", 64'(instReady), 64'(1'b1));
        while (acceptedCount < numInsts) begin
            draw        = drawRandom();
            resultReady = (acceptedCount < fixedReady) ? 1'b1 : draw[31];
            // Hold the instruction until it has been taken
            if (acceptedCount == issued) begin
                if (issued < numInsts && draw[30:29] != 2'b00) begin
                    inst      = makeInst();
                    instValid = 1'b1;
                    issued++;
                end else begin
                    instValid = 1'b0;
                end
            end
            @(negedge clk);
        end
        // Pipeline empties within three edges, the rest catches duplicates
        instValid   = 1'b0;
        resultReady = 1'b1;
        repeat (6) @(negedge clk);
        if (pendingQ.size() != 0) begin
            abortRun("Instructions were accepted but never produced a result");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
source/isaPkg.sv
source/pipePkg.sv
source/regFile.sv
source/instDecode.sv
source/aluExecute.sv
source/resultStage.sv
source/pipeTop.sv
testbench/pipeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module pipeTb -o pipeSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pipeSim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
